/* src.f */
logic/debug_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/debug_sequencer.sv
logic/program_loader.sv
logic/run_control.sv
logic/debug_unit_top.sv
testbench/tb_debug_unit.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_debug_unit -f src.f -o tb_debug_unit \
    > sim.log 2>&1 \
    && ./obj_dir/tb_debug_unit >> sim.log 2>&1 \
    || echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

/* testbench/debug_stimulus.txt */
// Each entry is T_II_VVVVVVVV: tag T, index II, value VVVVVVVV (hex)
// T=1 register II, T=2 memory word at II, T=3 program word II, T=4 command opcode II, arg V
1_00_00000000 1_01_1234ABCD 1_02_DEADBEEF 1_03_0BADF00D
1_04_FFFFFFFF 1_05_80000001 1_06_00FF00FF 1_07_A5A55A5A
1_08_01020304 1_09_11111111 1_0A_22222222 1_0B_33333333
1_0C_44444444 1_0D_55555555 1_0E_66666666 1_0F_77777777
1_10_88888888 1_11_99999999 1_12_AAAAAAAA 1_13_BBBBBBBB
1_14_CCCCCCCC 1_15_DDDDDDDD 1_16_EEEEEEEE 1_17_13579BDF
1_18_2468ACE0 1_19_FEDCBA98 1_1A_76543210 1_1B_C3C3C3C3
1_1C_3C3C3C3C 1_1D_0F1E2D3C 1_1E_4B5A6978 1_1F_87654321
// Memory words, other addresses keep the fill pattern
2_05_CAFEF00D 2_12_13579BDF 2_3F_80000001
// Program words, count is the number of entries
3_00_00500093 3_01_00A00113 3_02_002081B3
// Commands: dump, memory reads, unknown opcode, load, steps
4_01_00000000 4_0B_00000005 4_0B_00000012 4_0B_0000002A
4_55_00000000 4_07_00000000 4_0A_00000003 4_08_00000000
4_0A_00000001 4_09_00000000 4_3C_00000000 4_0A_00000002
4_0B_0000003F 4_01_00000000

/* testbench/tb_debug_unit.sv */
`default_nettype none

module tb_debug_unit;

    import debug_pkg::*;

    localparam int CLKS_PER_BIT  = 8;
    localparam int BYTE_TIMEOUT  = 40 * CLKS_PER_BIT; // Cycles allowed per reply byte
    localparam int SETTLE_CYCLES = 20 * CLKS_PER_BIT;
    localparam int NUM_ENTRIES   = 64;

    logic                                i_clk;
    logic                                i_reset;
    logic                                i_uart_rx;
    logic [NUM_REGISTERS*DATA_WIDTH-1:0] i_registers;
    logic [DATA_WIDTH-1:0]               i_dmem_data;
    wire                                 o_uart_tx;
    wire  [DMEM_ADDR_WIDTH-1:0]          o_dmem_addr;
    wire                                 o_imem_we;
    wire  [IMEM_ADDR_WIDTH-1:0]          o_imem_addr;
    wire  [DATA_WIDTH-1:0]               o_imem_data;
    wire                                 o_cpu_clk_en;
    wire                                 o_cpu_reset;
    wire                                 o_step_mode;

    logic [43:0]                stim [NUM_ENTRIES];
    logic [DATA_WIDTH-1:0]      regs [NUM_REGISTERS];
    logic [DATA_WIDTH-1:0]      dmem [2**DMEM_ADDR_WIDTH];
    logic [DATA_WIDTH-1:0]      prog_words [$];
    logic [7:0]                 cmd_ops [$];
    logic [31:0]                cmd_args [$];
    logic [7:0]                 reply_q [$];
    logic [IMEM_ADDR_WIDTH-1:0] we_addr_q [$];
    logic [DATA_WIDTH-1:0]      we_data_q [$];
    logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_q;
    logic [7:0]                 lfsr;
    logic                       model_step_mode;
    logic                       clk_en_prev;
    int                         clk_en_cycles;
    int                         clk_en_pulses;
    int                         reset_len;
    int                         last_reset_len;
    int                         value_errors;
    int                         timeout_errors;
    int                         frame_errors;

    debug_unit_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        if (state[0])
            return (state >> 1) ^ 8'hB8; // Galois taps for x^8+x^6+x^5+x^4+1
        else
            return state >> 1;
    endfunction

    task automatic report_mismatch(input string test, input int index,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("** Error %s [%0d]: expected %h, actual %h", test, index, expected, actual);
        value_errors++;
    endtask

    task automatic load_stimulus();
        foreach (stim[k])
            stim[k] = '0;
        foreach (regs[r])
            regs[r] = '0;
        foreach (dmem[a])
            dmem[a] = 32'hC0DE0000 ^ (32'(a) * 32'h00010101);
        $readmemh("testbench/debug_stimulus.txt", stim);
        foreach (stim[k]) begin
            case (stim[k][43:40])
                4'h1: regs[stim[k][36:32]] = stim[k][31:0];
                4'h2: dmem[stim[k][37:32]] = stim[k][31:0];
                4'h3: prog_words.push_back(stim[k][31:0]);
                4'h4: begin
                    cmd_ops.push_back(stim[k][39:32]);
                    cmd_args.push_back(stim[k][31:0]);
                end
                default: ;
            endcase
        end
    endtask

    task automatic drive_bit(input logic value);
        @(negedge i_clk);
        i_uart_rx = value;
        repeat (CLKS_PER_BIT - 1) @(negedge i_clk);
    endtask

    task automatic send_frame(input logic [7:0] data);
        logic [2:0] gap;
        for (int g = 0; g < 3; g++) begin
            lfsr   = lfsr_step(lfsr);
            gap[g] = lfsr[0];
        end
        repeat (int'(gap) * CLKS_PER_BIT) @(negedge i_clk); // Idle gap of 0 to 7 bit times
        drive_bit(1'b0);
        for (int b = 0; b < 8; b++)
            drive_bit(data[b]);
        drive_bit(1'b1);
    endtask

    task automatic wait_for_reply(input int count, input string what, output bit ok);
        int cycles;
        cycles = 0;
        while (reply_q.size() < count && cycles < count * BYTE_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        ok = (reply_q.size() >= count);
        if (!ok) begin
            $display("Timeout: %s received %0d of %0d reply bytes", what, reply_q.size(), count);
            timeout_errors++;
        end
    endtask

    task automatic run_command(input logic [7:0] op, input logic [31:0] arg);
        logic [31:0] word;
        int          en_start;
        int          pulse_start;
        int          cycles;
        int          expected;
        bit          ok;
        reply_q.delete();
        case (op)
            CMD_DUMP_REGS: begin
                send_frame(op);
                wait_for_reply(NUM_REGISTERS * BYTES_PER_WORD + 1, "register dump", ok);
                if (ok) begin
                    for (int r = 0; r < NUM_REGISTERS; r++)
                        for (int b = 0; b < BYTES_PER_WORD; b++)
                            if (reply_q[r*BYTES_PER_WORD+b] !== regs[r][8*b +: 8])
                                report_mismatch("register dump byte", r*BYTES_PER_WORD+b,
                                    32'(regs[r][8*b +: 8]), 32'(reply_q[r*BYTES_PER_WORD+b]));
                    if (reply_q[NUM_REGISTERS*BYTES_PER_WORD] !== ACK_BYTE)
                        report_mismatch("register dump ack", 0, 32'(ACK_BYTE),
                            32'(reply_q[NUM_REGISTERS*BYTES_PER_WORD]));
                end
            end
            CMD_READ_MEM: begin
                send_frame(op);
                send_frame(arg[7:0]);
                wait_for_reply(BYTES_PER_WORD + 1, "memory read", ok);
                if (ok) begin
                    word = {reply_q[3], reply_q[2], reply_q[1], reply_q[0]};
                    if (word !== dmem[arg[DMEM_ADDR_WIDTH-1:0]])
                        report_mismatch("memory read data", int'(arg),
                            dmem[arg[DMEM_ADDR_WIDTH-1:0]], word);
                    if (reply_q[4] !== ACK_BYTE)
                        report_mismatch("memory read ack", int'(arg), 32'(ACK_BYTE),
                            32'(reply_q[4]));
                    if (o_dmem_addr !== arg[DMEM_ADDR_WIDTH-1:0])
                        report_mismatch("memory read address", int'(arg), arg,
                            32'(o_dmem_addr));
                end
            end
            CMD_LOAD_PROGRAM: begin
                we_addr_q.delete();
                we_data_q.delete();
                send_frame(op);
                send_frame(8'(prog_words.size()));
                foreach (prog_words[w])
                    for (int b = 0; b < BYTES_PER_WORD; b++)
                        send_frame(prog_words[w][8*b +: 8]);
                model_step_mode = 1'b1;
                wait_for_reply(1, "program load", ok);
                if (ok) begin
                    if (reply_q[0] !== ACK_BYTE)
                        report_mismatch("load ack", 0, 32'(ACK_BYTE), 32'(reply_q[0]));
                    if (we_addr_q.size() != prog_words.size())
                        report_mismatch("load write count", 0, prog_words.size(),
                            we_addr_q.size());
                    foreach (we_addr_q[w]) begin
                        if (w < prog_words.size() && we_addr_q[w] !== IMEM_ADDR_WIDTH'(w))
                            report_mismatch("load write address", w, w, 32'(we_addr_q[w]));
                        if (w < prog_words.size() && we_data_q[w] !== prog_words[w])
                            report_mismatch("load write data", w, prog_words[w], we_data_q[w]);
                    end
                    if (last_reset_len != PROG_RESET_CYCLES)
                        report_mismatch("cpu reset length", 0, PROG_RESET_CYCLES,
                            last_reset_len);
                    if (o_step_mode !== 1'b1)
                        report_mismatch("step mode after load", 0, 1, 32'(o_step_mode));
                end
            end
            CMD_STEP: begin
                expected = model_step_mode ? int'(arg) : 0; // Continuous mode ignores steps
                @(posedge i_clk);
                en_start    = clk_en_cycles;
                pulse_start = clk_en_pulses;
                for (int s = 0; s < int'(arg); s++)
                    send_frame(op);
                cycles = 0;
                while (clk_en_pulses - pulse_start < expected && cycles < BYTE_TIMEOUT) begin
                    @(negedge i_clk);
                    cycles++;
                end
                repeat (SETTLE_CYCLES) @(posedge i_clk);
                if (clk_en_pulses - pulse_start != expected)
                    report_mismatch("step pulse count", int'(arg), expected,
                        clk_en_pulses - pulse_start);
                if (model_step_mode && clk_en_cycles - en_start != expected)
                    report_mismatch("step enable cycles", int'(arg), expected,
                        clk_en_cycles - en_start);
                if (reply_q.size() != 0)
                    report_mismatch("step reply bytes", int'(arg), 0, reply_q.size());
            end
            default: begin
                if (op == CMD_RUN_CONTINUOUS)
                    model_step_mode = 1'b0;
                else if (op == CMD_RUN_STEP)
                    model_step_mode = 1'b1;
                send_frame(op);
                cycles = 0;
                while (o_step_mode !== model_step_mode && cycles < BYTE_TIMEOUT) begin
                    @(negedge i_clk);
                    cycles++;
                end
                @(posedge i_clk);
                en_start = clk_en_cycles;
                repeat (SETTLE_CYCLES) @(posedge i_clk);
                expected = model_step_mode ? 0 : SETTLE_CYCLES;
                if (o_step_mode !== model_step_mode)
                    report_mismatch("step mode", int'(op), 32'(model_step_mode),
                        32'(o_step_mode));
                if (clk_en_cycles - en_start != expected)
                    report_mismatch("clock enable cycles", int'(op), expected,
                        clk_en_cycles - en_start);
                if (reply_q.size() != 0)
                    report_mismatch("reply bytes", int'(op), 0, reply_q.size());
            end
        endcase
    endtask

    initial begin : dmem_model
        i_dmem_data = '0;
        dmem_addr_q = '0;
        forever begin
            @(negedge i_clk);
            i_dmem_data = dmem[dmem_addr_q]; // One cycle behind the address
            dmem_addr_q = o_dmem_addr;
        end
    end

    initial begin : output_monitor
        clk_en_cycles  = 0;
        clk_en_pulses  = 0;
        reset_len      = 0;
        last_reset_len = 0;
        clk_en_prev    = 1'b0;
        forever begin
            @(negedge i_clk);
            if (o_imem_we === 1'b1) begin
                we_addr_q.push_back(o_imem_addr);
                we_data_q.push_back(o_imem_data);
            end
            if (o_cpu_clk_en === 1'b1)
                clk_en_cycles++;
            if (o_cpu_clk_en === 1'b1 && !clk_en_prev)
                clk_en_pulses++;
            clk_en_prev = (o_cpu_clk_en === 1'b1);
            if (o_cpu_reset === 1'b1) begin
                reset_len++;
            end else if (reset_len != 0) begin
                last_reset_len = reset_len;
                reset_len      = 0;
            end
        end
    end

    initial begin : reply_decoder
        logic [7:0] shift;
        frame_errors = 0;
        shift        = '0;
        forever begin
            @(negedge i_clk);
            if (!i_reset && o_uart_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge i_clk); // Middle of start bit
                for (int b = 0; b < 8; b++) begin
                    repeat (CLKS_PER_BIT) @(negedge i_clk);
                    shift = {o_uart_tx, shift[7:1]};
                end
                repeat (CLKS_PER_BIT) @(negedge i_clk);
                if (o_uart_tx !== 1'b1) begin
                    $display("Reply frame has a low stop bit");
                    frame_errors++;
                end
                reply_q.push_back(shift);
            end
        end
    end

    initial begin : main_sequence
        i_reset         = 1'b1;
        i_uart_rx       = 1'b1;
        i_registers     = '0;
        lfsr            = 8'd96;
        model_step_mode = 1'b0;
        value_errors    = 0;
        timeout_errors  = 0;
        load_stimulus();
        for (int r = 0; r < NUM_REGISTERS; r++)
            i_registers[r*DATA_WIDTH +: DATA_WIDTH] = regs[r];
        repeat (2) @(negedge i_clk);
        i_reset = 1'b0;
        for (int c = 0; c < cmd_ops.size(); c++)
            run_command(cmd_ops[c], cmd_args[c]);
        $display("Errors: %0d value, %0d timeout, %0d reply frame",
                 value_errors, timeout_errors, frame_errors);
        if (value_errors == 0 && timeout_errors == 0 && frame_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/debug_unit_top.sv */
`default_nettype none

module debug_unit_top #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire                                   i_clk,
    input  wire                                   i_reset,
    input  wire                                   i_uart_rx,
    output wire                                   o_uart_tx,
    input  wire [debug_pkg::NUM_REGISTERS*debug_pkg::DATA_WIDTH-1:0] i_registers,
    output wire [debug_pkg::DMEM_ADDR_WIDTH-1:0]  o_dmem_addr,
    input  wire [debug_pkg::DATA_WIDTH-1:0]       i_dmem_data,
    output wire                                   o_imem_we,
    output wire [debug_pkg::IMEM_ADDR_WIDTH-1:0]  o_imem_addr,
    output wire [debug_pkg::DATA_WIDTH-1:0]       o_imem_data,
    output wire                                   o_cpu_clk_en,
    output wire                                   o_cpu_reset,
    output wire                                   o_step_mode
);

    wire       rx_valid;
    wire [7:0] rx_byte;
    wire       tx_start;
    wire [7:0] tx_byte;
    wire       tx_busy;
    wire       count_valid;
    wire       byte_valid;
    wire [7:0] load_byte; // Count byte, then program bytes
    wire       load_done;
    wire       set_continuous;
    wire       set_step;
    wire       step_req;
    wire       start_prog_reset;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_rx    (i_uart_rx),
        .o_byte  (rx_byte),
        .o_valid (rx_valid)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_start (tx_start),
        .i_byte  (tx_byte),
        .o_tx    (o_uart_tx),
        .o_busy  (tx_busy)
    );

    debug_sequencer sequencer_i (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_rx_valid         (rx_valid),
        .i_rx_byte          (rx_byte),
        .i_tx_busy          (tx_busy),
        .i_registers        (i_registers),
        .i_dmem_data        (i_dmem_data),
        .i_load_done        (load_done),
        .i_cpu_reset        (o_cpu_reset),
        .o_tx_start         (tx_start),
        .o_tx_byte          (tx_byte),
        .o_dmem_addr        (o_dmem_addr),
        .o_count_valid      (count_valid),
        .o_byte_valid       (byte_valid),
        .o_load_byte        (load_byte),
        .o_set_continuous   (set_continuous),
        .o_set_step         (set_step),
        .o_step_req         (step_req),
        .o_start_prog_reset (start_prog_reset)
    );

    program_loader loader_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_count_valid (count_valid),
        .i_count       (load_byte),
        .i_byte_valid  (byte_valid),
        .i_byte        (load_byte),
        .o_imem_we     (o_imem_we),
        .o_imem_addr   (o_imem_addr),
        .o_imem_data   (o_imem_data),
        .o_load_done   (load_done)
    );

    run_control run_ctrl_i (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_set_continuous   (set_continuous),
        .i_set_step         (set_step),
        .i_step_req         (step_req),
        .i_start_prog_reset (start_prog_reset),
        .o_step_mode        (o_step_mode),
        .o_cpu_clk_en       (o_cpu_clk_en),
        .o_cpu_reset        (o_cpu_reset)
    );

endmodule

`default_nettype wire

/* logic/run_control.sv */
`default_nettype none

module run_control (
    input  wire  i_clk,
    input  wire  i_reset,
    input  wire  i_set_continuous,
    input  wire  i_set_step,
    input  wire  i_step_req,
    input  wire  i_start_prog_reset,
    output logic o_step_mode,
    output logic o_cpu_clk_en,
    output logic o_cpu_reset
);

    import debug_pkg::*;

    localparam int RW = $clog2(PROG_RESET_CYCLES);
    localparam logic [RW-1:0] RESET_LAST = RW'(PROG_RESET_CYCLES - 1);

    logic          step_pulse;
    logic [RW-1:0] reset_cnt;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_step_mode <= 1'b0; // Continuous after reset
            o_cpu_reset <= 1'b0;
            step_pulse  <= 1'b0;
            reset_cnt   <= '0;
        end else begin
            step_pulse <= i_step_req && o_step_mode;
            if (i_start_prog_reset) begin
                o_step_mode <= 1'b1;
                o_cpu_reset <= 1'b1;
                reset_cnt   <= '0;
            end else begin
                if (i_set_step)
                    o_step_mode <= 1'b1;
                else if (i_set_continuous)
                    o_step_mode <= 1'b0;
                if (o_cpu_reset) begin
                    reset_cnt <= reset_cnt + 1'b1;
                    if (reset_cnt == RESET_LAST)
                        o_cpu_reset <= 1'b0;
                end
            end
        end
    end

    assign o_cpu_clk_en = o_step_mode ? step_pulse : !o_cpu_reset;

    a_reset_len: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_cpu_reset) |-> ##PROG_RESET_CYCLES $fell(o_cpu_reset));

endmodule

`default_nettype wire

/* logic/program_loader.sv */
`default_nettype none

module program_loader (
    input  wire                                   i_clk,
    input  wire                                   i_reset,
    input  wire                                   i_count_valid,
    input  wire  [7:0]                            i_count,
    input  wire                                   i_byte_valid,
    input  wire  [7:0]                            i_byte,
    output logic                                  o_imem_we,
    output logic [debug_pkg::IMEM_ADDR_WIDTH-1:0] o_imem_addr,
    output logic [debug_pkg::DATA_WIDTH-1:0]      o_imem_data,
    output logic                                  o_load_done
);

    import debug_pkg::*;

    localparam int PW = $clog2(BYTES_PER_WORD);
    localparam logic [PW-1:0] POS_LAST = PW'(BYTES_PER_WORD - 1);

    logic [7:0]            words_left;
    logic [PW-1:0]         byte_pos;
    logic [DATA_WIDTH-1:0] word_buf;
    logic                  take_byte;

    assign take_byte   = i_byte_valid && (words_left != 8'd0);
    assign o_imem_data = word_buf;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            words_left  <= '0;
            byte_pos    <= '0;
            o_imem_addr <= '0;
            o_imem_we   <= 1'b0;
            o_load_done <= 1'b0;
        end else begin
            o_imem_we   <= 1'b0;
            o_load_done <= 1'b0;
            if (o_imem_we)
                o_imem_addr <= o_imem_addr + 1'b1;
            if (i_count_valid) begin
                words_left  <= i_count;
                byte_pos    <= '0;
                o_imem_addr <= '0;
                o_load_done <= (i_count == 8'd0); // Empty program
            end else if (take_byte) begin
                byte_pos <= byte_pos + 1'b1;
                if (byte_pos == POS_LAST) begin
                    o_imem_we   <= 1'b1;
                    words_left  <= words_left - 1'b1;
                    o_load_done <= (words_left == 8'd1);
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_byte)
            word_buf <= {i_byte, word_buf[DATA_WIDTH-1:8]}; // Little endian
    end

    a_we_single: assert property (@(posedge i_clk) disable iff (i_reset)
        o_imem_we |=> !o_imem_we);

endmodule

`default_nettype wire

/* logic/debug_sequencer.sv */
`default_nettype none

module debug_sequencer (
    input  wire                                         i_clk,
    input  wire                                         i_reset,
    input  wire                                         i_rx_valid,
    input  wire  [7:0]                                  i_rx_byte,
    input  wire                                         i_tx_busy,
    input  wire  [debug_pkg::NUM_REGISTERS*debug_pkg::DATA_WIDTH-1:0] i_registers,
    input  wire  [debug_pkg::DATA_WIDTH-1:0]            i_dmem_data,
    input  wire                                         i_load_done,
    input  wire                                         i_cpu_reset,
    output logic                                        o_tx_start,
    output logic [7:0]                                  o_tx_byte,
    output logic [debug_pkg::DMEM_ADDR_WIDTH-1:0]       o_dmem_addr,
    output logic                                        o_count_valid,
    output logic                                        o_byte_valid,
    output logic [7:0]                                  o_load_byte,
    output logic                                        o_set_continuous,
    output logic                                        o_set_step,
    output logic                                        o_step_req,
    output logic                                        o_start_prog_reset
);

    import debug_pkg::*;

    localparam int NUM_BYTES = NUM_REGISTERS * BYTES_PER_WORD;
    localparam int IW = $clog2(NUM_BYTES);
    localparam logic [IW-1:0] DUMP_LAST = IW'(NUM_BYTES - 1);
    localparam logic [IW-1:0] WORD_LAST = IW'(BYTES_PER_WORD - 1);

    seq_state_e            state;
    logic [IW-1:0]         byte_idx;
    logic [IW-1:0]         byte_last;
    logic                  dump_sel; // Register file or latched memory word
    logic                  reset_seen;
    logic [DATA_WIDTH-1:0] mem_word;
    logic [7:0]            reply_byte;

    always_comb begin
        if (dump_sel)
            reply_byte = i_registers[{byte_idx, 3'b000} +: 8];
        else
            reply_byte = mem_word[{byte_idx[1:0], 3'b000} +: 8];
    end

    assign o_tx_start = (state == S_SEND_BYTE || state == S_SEND_ACK) && !i_tx_busy;
    assign o_tx_byte  = (state == S_SEND_ACK) ? ACK_BYTE : reply_byte;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state              <= S_IDLE;
            byte_idx           <= '0;
            byte_last          <= '0;
            dump_sel           <= 1'b0;
            reset_seen         <= 1'b0;
            o_dmem_addr        <= '0;
            o_count_valid      <= 1'b0;
            o_byte_valid       <= 1'b0;
            o_set_continuous   <= 1'b0;
            o_set_step         <= 1'b0;
            o_step_req         <= 1'b0;
            o_start_prog_reset <= 1'b0;
        end else begin
            o_count_valid      <= 1'b0;
            o_byte_valid       <= 1'b0;
            o_set_continuous   <= 1'b0;
            o_set_step         <= 1'b0;
            o_step_req         <= 1'b0;
            o_start_prog_reset <= 1'b0;
            case (state)
                S_IDLE: begin
                    byte_idx   <= '0;
                    reset_seen <= 1'b0;
                    if (i_rx_valid) begin
                        case (i_rx_byte)
                            CMD_DUMP_REGS: begin
                                dump_sel  <= 1'b1;
                                byte_last <= DUMP_LAST;
                                state     <= S_SEND_BYTE;
                            end
                            CMD_READ_MEM:       state <= S_GET_ADDR;
                            CMD_LOAD_PROGRAM:   state <= S_GET_COUNT;
                            CMD_RUN_CONTINUOUS: o_set_continuous <= 1'b1;
                            CMD_RUN_STEP:       o_set_step <= 1'b1;
                            CMD_STEP:           o_step_req <= 1'b1;
                            default:            state <= S_IDLE; // Unknown opcode gets no reply
                        endcase
                    end
                end
                S_GET_ADDR: begin
                    if (i_rx_valid) begin
                        o_dmem_addr <= i_rx_byte[DMEM_ADDR_WIDTH-1:0];
                        state       <= S_MEM_WAIT;
                    end
                end
                S_MEM_WAIT: begin
                    byte_idx <= byte_idx + 1'b1;
                    if (byte_idx[0]) begin // Data valid the cycle after the address
                        byte_idx  <= '0;
                        dump_sel  <= 1'b0;
                        byte_last <= WORD_LAST;
                        state     <= S_SEND_BYTE;
                    end
                end
                S_SEND_BYTE: begin
                    if (!i_tx_busy)
                        state <= S_WAIT_TX;
                end
                S_WAIT_TX: begin
                    if (!i_tx_busy) begin
                        if (byte_idx == byte_last) begin
                            state <= S_SEND_ACK;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= S_SEND_BYTE;
                        end
                    end
                end
                S_GET_COUNT: begin
                    if (i_rx_valid) begin
                        o_count_valid <= 1'b1;
                        state         <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    o_byte_valid <= i_rx_valid;
                    if (i_load_done) begin
                        o_start_prog_reset <= 1'b1;
                        state              <= S_WAIT_RESET;
                    end
                end
                S_WAIT_RESET: begin
                    if (i_cpu_reset)
                        reset_seen <= 1'b1;
                    else if (reset_seen)
                        state <= S_SEND_ACK; // Reset pulse is over
                end
                S_SEND_ACK: begin
                    if (!i_tx_busy)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rx_valid)
            o_load_byte <= i_rx_byte;
        if (state == S_MEM_WAIT && byte_idx[0])
            mem_word <= i_dmem_data;
    end

    a_state_legal: assert property (@(posedge i_clk) disable iff (i_reset)
        state inside {S_IDLE, S_GET_ADDR, S_MEM_WAIT, S_SEND_BYTE, S_WAIT_TX,
                      S_GET_COUNT, S_LOAD, S_WAIT_RESET, S_SEND_ACK});

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire       i_clk,
    input  wire       i_reset,
    input  wire       i_start,
    input  wire [7:0] i_byte,
    output logic      o_tx,
    output logic      o_busy
);

    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);

    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;
    logic [8:0]    shreg; // Data bits then stop bit

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_tx    <= 1'b1;
            o_busy  <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!o_busy) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            if (i_start) begin
                o_tx   <= 1'b0; // Start bit
                o_busy <= 1'b1;
            end
        end else if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            o_tx    <= shreg[0];
            if (bit_idx == 4'd9)
                o_busy <= 1'b0; // End of stop bit
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!o_busy && i_start)
            shreg <= {1'b1, i_byte};
        else if (o_busy && clk_cnt == BIT_LAST)
            shreg <= {1'b1, shreg[8:1]};
    end

    a_no_start_while_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_start && o_busy));

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_rx,
    output logic [7:0] o_byte,
    output logic       o_valid
);

    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] BIT_LAST  = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e     state;
    logic [1:0]    rx_sync;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_idx;
    logic          bit_end;

    assign bit_end = (clk_cnt == BIT_LAST);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            rx_sync <= 2'b11; // Line idles high
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
            o_valid <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync[1])
                        state <= RX_START;
                end
                RX_START: begin
                    if (clk_cnt == HALF_LAST) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync[1] ? RX_IDLE : RX_DATA; // Glitch, not a start bit
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                default: begin
                    if (bit_end) begin
                        o_valid <= rx_sync[1]; // Framing error drops the byte
                        state   <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_end)
            o_byte <= {rx_sync[1], o_byte[7:1]}; // LSB first
    end

endmodule

`default_nettype wire

/* logic/debug_pkg.sv */
`default_nettype none

package debug_pkg;

    localparam int DATA_WIDTH        = 32;
    localparam int NUM_REGISTERS     = 32;
    localparam int BYTES_PER_WORD    = 4;
    localparam int IMEM_ADDR_WIDTH   = 6;
    localparam int DMEM_ADDR_WIDTH   = 6;
    localparam int PROG_RESET_CYCLES = 16;

    localparam logic [7:0] ACK_BYTE = 8'h52; // ASCII "R"

    typedef enum logic [7:0] {
        CMD_DUMP_REGS      = 8'h01,
        CMD_LOAD_PROGRAM   = 8'h07,
        CMD_RUN_CONTINUOUS = 8'h08,
        CMD_RUN_STEP       = 8'h09,
        CMD_STEP           = 8'h0A,
        CMD_READ_MEM       = 8'h0B
    } cmd_e;

    typedef enum logic [3:0] {
        S_IDLE,
        S_GET_ADDR,
        S_MEM_WAIT,
        S_SEND_BYTE,
        S_WAIT_TX,
        S_GET_COUNT,
        S_LOAD,
        S_WAIT_RESET,
        S_SEND_ACK
    } seq_state_e;

endpackage

`default_nettype wire
